// File: src/nes_host_defines.svh
`ifndef NES_HOST_DEFINES_SVH
`define NES_HOST_DEFINES_SVH

// memory and bus widths
`define NES_ADDR_W 25
`define NES_PPU_ADDR_W 22
`define NES_SAVE_ADDR_W 18
`define NES_FLAGS_W 64

// post-download reset countdown
`define NES_RESET_COUNT 255
`define NES_COUNT_W 8

// four player adapter id bytes, shifted out after the second pad
`define NES_TAP_SIG_P1 8'h08
`define NES_TAP_SIG_P2 8'h04

// save ram sits at this upper address slice of the sdram
`define NES_SAVE_BASE 7'b0001111

// battery backed prg ram flag from the loader
`define NES_HAS_SAVE_BIT 25

`endif

// File: src/nes_host_pkg.sv
`default_nettype none

`include "nes_host_defines.svh"

package nes_host_pkg;

  // sdram side addresses
  typedef logic [`NES_ADDR_W-1:0] mem_addr_t;
  typedef logic [`NES_PPU_ADDR_W-1:0] ppu_addr_t;
  typedef logic [`NES_SAVE_ADDR_W-1:0] save_addr_t;
  typedef logic [7:0] mem_data_t;

  // header info decoded by the loader
  typedef logic [`NES_FLAGS_W-1:0] mapper_flags_t;

  // msb first: right, left, down, up, start, select, b, a
  typedef logic [7:0] pad_buttons_t;

  // one controller port, pad byte in the low bits
  typedef logic [23:0] serial_word_t;

  typedef enum logic [1:0] {
    wait_download,
    downloading,
    countdown,
    run
  } reset_state_t;

endpackage

`default_nettype wire

// File: src/reset_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "nes_host_defines.svh"

module reset_sequencer (
  input  wire  clk_ppu_21_47,
  input  wire  reset_nes,
  input  wire  downloading,
  input  wire  loader_busy,
  input  wire  loader_fail,
  output logic core_reset,
  output logic loader_reset
);

  import nes_host_pkg::*;

  reset_state_t           state;
  logic [`NES_COUNT_W-1:0] count;
  logic                   downloading_q;
  // survives reset_nes so a cart stays loaded across a soft reset
  logic                   init_done = 1'b0;

  always_ff @(posedge clk_ppu_21_47) begin
    if (downloading) begin
      init_done <= 1'b1;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state <= init_done ? run : wait_download;
      count <= '0;
    end else if (downloading) begin
      state <= nes_host_pkg::downloading;
      count <= `NES_COUNT_W'(`NES_RESET_COUNT);
    end else begin
      case (state)
        wait_download: state <= wait_download;
        // first cycle after the download ends already counts
        nes_host_pkg::downloading: begin
          state <= countdown;
          if (!loader_busy) begin
            count <= count - 1'b1;
          end
        end
        countdown: begin
          if (!loader_busy) begin
            count <= count - 1'b1;
            if (count == `NES_COUNT_W'(1)) begin
              state <= run;
            end
          end
        end
        run: state <= run;
        default: state <= wait_download;
      endcase
    end
  end

  // loader stays in reset while idle, plus a pulse as a download starts
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      downloading_q <= 1'b0;
      loader_reset  <= 1'b0;
    end else begin
      downloading_q <= downloading;
      loader_reset  <= (count == '0) || (downloading && !downloading_q);
    end
  end

  assign core_reset = reset_nes || loader_fail || (state != run);

endmodule

`default_nettype wire

// File: src/cart_config_reg.sv
`timescale 1ns/1ns
`default_nettype none

`include "nes_host_defines.svh"

module cart_config_reg (
  input  wire                         clk_ppu_21_47,
  input  wire                         reset_nes,
  input  wire                         loader_done,
  input  nes_host_pkg::mapper_flags_t loader_flags,
  input  wire                         downloading,
  input  wire                         multitap_enabled,
  output logic                        has_save,
  output logic                        multitap_ok
);

  import nes_host_pkg::*;

  mapper_flags_t mapper_flags;
  mapper_flags_t core_flags;

  // captured once the loader has parsed the header
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      mapper_flags <= '0;
    end else if (loader_done) begin
      mapper_flags <= loader_flags;
    end
  end

  // core sees no cartridge while a new image streams in
  assign core_flags = downloading ? '0 : mapper_flags;

  assign has_save = core_flags[`NES_HAS_SAVE_BIT];

  // no adapter id bytes until a cart configuration is present
  assign multitap_ok = multitap_enabled && (core_flags != '0);

endmodule

`default_nettype wire

// File: src/joypad_serializer.sv
`timescale 1ns/1ns
`default_nettype none

`include "nes_host_defines.svh"

module joypad_serializer (
  input  wire                        clk_ppu_21_47,
  input  wire                        core_reset,
  input  wire                        joypad_strobe,
  input  wire                  [1:0] joypad_clock,
  input  nes_host_pkg::pad_buttons_t p1_pad,
  input  nes_host_pkg::pad_buttons_t p2_pad,
  input  nes_host_pkg::pad_buttons_t p3_pad,
  input  nes_host_pkg::pad_buttons_t p4_pad,
  input  wire                        multitap_ok,
  input  wire                        swap_controllers,
  output logic                       joypad1_data,
  output logic                       joypad2_data
);

  import nes_host_pkg::*;

  // index 0 is port 1, index 1 is port 2
  serial_word_t shift_reg [2];
  serial_word_t load_word [2];
  pad_buttons_t port_pad  [2];
  logic   [1:0] last_clock;
  logic   [1:0] clock_fall;

  // swap exchanges only the first two pads
  always_comb begin
    port_pad[0] = swap_controllers ? p2_pad : p1_pad;
    port_pad[1] = swap_controllers ? p1_pad : p2_pad;
  end

  // without the adapter the unused bits read as ones
  always_comb begin
    load_word[0] = {multitap_ok ? {`NES_TAP_SIG_P1, p3_pad} : 16'hffff, port_pad[0]};
    load_word[1] = {multitap_ok ? {`NES_TAP_SIG_P2, p4_pad} : 16'hffff, port_pad[1]};
  end

  assign clock_fall = last_clock & ~joypad_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (core_reset) begin
      shift_reg[0] <= '0;
      shift_reg[1] <= '0;
      last_clock   <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (joypad_strobe) begin
          shift_reg[i] <= load_word[i];
        end
        // a falling clock wins over the strobe, as on the console
        if (clock_fall[i]) begin
          shift_reg[i] <= {1'b0, shift_reg[i][23:1]};
        end
      end
      last_clock <= joypad_clock;
    end
  end

  assign joypad1_data = shift_reg[0][0];
  assign joypad2_data = shift_reg[1][0];

endmodule

`default_nettype wire

// File: src/mem_channel_mux.sv
`timescale 1ns/1ns
`default_nettype none

`include "nes_host_defines.svh"

module mem_channel_mux (
  input  wire                      clk_ppu_21_47,
  input  wire                      reset_nes,
  input  wire                      downloading,
  input  wire                      loader_busy,
  input  nes_host_pkg::mem_addr_t  loader_addr,
  input  nes_host_pkg::mem_data_t  loader_wdata,
  input  wire                      loader_write,
  input  nes_host_pkg::ppu_addr_t  ppu_addr,
  input  nes_host_pkg::mem_data_t  ppu_wdata,
  input  wire                      ppu_read,
  input  wire                      ppu_write,
  input  wire                      sd_valid,
  input  wire                      sd_write,
  input  wire                      sd_read,
  input  nes_host_pkg::save_addr_t sd_addr,
  input  nes_host_pkg::mem_data_t  sd_wdata,
  input  wire                      ch2_busy,
  output logic                     sd_ready,
  output nes_host_pkg::mem_addr_t  ch0_addr,
  output nes_host_pkg::mem_data_t  ch0_din,
  output logic                     ch0_wr,
  output logic                     ch0_rd,
  output nes_host_pkg::mem_addr_t  ch2_addr,
  output nes_host_pkg::mem_data_t  ch2_din,
  output logic                     ch2_wr,
  output logic                     ch2_rd
);

  import nes_host_pkg::*;

  logic      loading;
  logic      sd_accept;
  mem_addr_t ppu_addr_ext;

  assign loading      = downloading || loader_busy;
  assign ppu_addr_ext = {{(`NES_ADDR_W - `NES_PPU_ADDR_W){1'b0}}, ppu_addr};

  // host holds its request until the controller is free
  assign sd_ready  = ~ch2_busy;
  assign sd_accept = sd_valid && sd_ready;

  // channel 0 data path
  always_ff @(posedge clk_ppu_21_47) begin
    ch0_addr <= loading ? loader_addr : ppu_addr_ext;
    ch0_din  <= loading ? loader_wdata : ppu_wdata;
    if (sd_accept) begin
      ch2_addr <= {`NES_SAVE_BASE, sd_addr};
      ch2_din  <= sd_wdata;
    end
  end

  // request strobes
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      ch0_wr <= 1'b0;
      ch0_rd <= 1'b0;
      ch2_wr <= 1'b0;
      ch2_rd <= 1'b0;
    end else begin
      ch0_wr <= loader_write || ppu_write;
      // ppu fetches would return half written rom
      ch0_rd <= !loading && ppu_read;
      ch2_wr <= sd_accept && sd_write;
      ch2_rd <= sd_accept && sd_read;
    end
  end

endmodule

`default_nettype wire

// File: src/nes_host_top.sv
`timescale 1ns/1ns
`default_nettype none

module nes_host_top (
  input  wire                         clk_ppu_21_47,
  input  wire                         reset_nes,
  input  wire                         downloading,
  input  wire                         loader_busy,
  input  wire                         loader_done,
  input  wire                         loader_fail,
  input  nes_host_pkg::mapper_flags_t loader_flags,
  input  nes_host_pkg::mem_addr_t     loader_addr,
  input  nes_host_pkg::mem_data_t     loader_wdata,
  input  wire                         loader_write,
  input  nes_host_pkg::ppu_addr_t     ppu_addr,
  input  nes_host_pkg::mem_data_t     ppu_wdata,
  input  wire                         ppu_read,
  input  wire                         ppu_write,
  input  nes_host_pkg::pad_buttons_t  p1_pad,
  input  nes_host_pkg::pad_buttons_t  p2_pad,
  input  nes_host_pkg::pad_buttons_t  p3_pad,
  input  nes_host_pkg::pad_buttons_t  p4_pad,
  input  wire                         multitap_enabled,
  input  wire                         swap_controllers,
  input  wire                         joypad_strobe,
  input  wire                   [1:0] joypad_clock,
  input  wire                         sd_valid,
  input  wire                         sd_write,
  input  wire                         sd_read,
  input  nes_host_pkg::save_addr_t    sd_addr,
  input  nes_host_pkg::mem_data_t     sd_wdata,
  input  wire                         ch2_busy,
  output logic                        core_reset,
  output logic                        loader_reset,
  output logic                        has_save,
  output logic                        joypad1_data,
  output logic                        joypad2_data,
  output logic                        sd_ready,
  output nes_host_pkg::mem_addr_t     ch0_addr,
  output nes_host_pkg::mem_data_t     ch0_din,
  output logic                        ch0_wr,
  output logic                        ch0_rd,
  output nes_host_pkg::mem_addr_t     ch2_addr,
  output nes_host_pkg::mem_data_t     ch2_din,
  output logic                        ch2_wr,
  output logic                        ch2_rd
);

  logic multitap_ok;

  reset_sequencer reset_sequencer_i (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .downloading   (downloading),
    .loader_busy   (loader_busy),
    .loader_fail   (loader_fail),
    .core_reset    (core_reset),
    .loader_reset  (loader_reset)
  );

  cart_config_reg cart_config_reg_i (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .loader_done      (loader_done),
    .loader_flags     (loader_flags),
    .downloading      (downloading),
    .multitap_enabled (multitap_enabled),
    .has_save         (has_save),
    .multitap_ok      (multitap_ok)
  );

  // controller ports restart with the console
  joypad_serializer joypad_serializer_i (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .core_reset       (core_reset),
    .joypad_strobe    (joypad_strobe),
    .joypad_clock     (joypad_clock),
    .p1_pad           (p1_pad),
    .p2_pad           (p2_pad),
    .p3_pad           (p3_pad),
    .p4_pad           (p4_pad),
    .multitap_ok      (multitap_ok),
    .swap_controllers (swap_controllers),
    .joypad1_data     (joypad1_data),
    .joypad2_data     (joypad2_data)
  );

  mem_channel_mux mem_channel_mux_i (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .downloading   (downloading),
    .loader_busy   (loader_busy),
    .loader_addr   (loader_addr),
    .loader_wdata  (loader_wdata),
    .loader_write  (loader_write),
    .ppu_addr      (ppu_addr),
    .ppu_wdata     (ppu_wdata),
    .ppu_read      (ppu_read),
    .ppu_write     (ppu_write),
    .sd_valid      (sd_valid),
    .sd_write      (sd_write),
    .sd_read       (sd_read),
    .sd_addr       (sd_addr),
    .sd_wdata      (sd_wdata),
    .ch2_busy      (ch2_busy),
    .sd_ready      (sd_ready),
    .ch0_addr      (ch0_addr),
    .ch0_din       (ch0_din),
    .ch0_wr        (ch0_wr),
    .ch0_rd        (ch0_rd),
    .ch2_addr      (ch2_addr),
    .ch2_din       (ch2_din),
    .ch2_wr        (ch2_wr),
    .ch2_rd        (ch2_rd)
  );

endmodule

`default_nettype wire

// File: bench/nes_host_assert.sv
`timescale 1ns/1ns
`default_nettype none

module nes_host_assert (
  input wire clk_ppu_21_47,
  input wire reset_nes,
  input wire loader_fail,
  input wire core_reset,
  input wire sd_valid,
  input wire sd_ready,
  input wire ch2_wr,
  input wire ch2_rd
);

  // number of failed assertions
  int fail_count = 0;

  // a ch2 strobe follows an accepted save request
  ch2_strobe_accepted: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    (ch2_wr || ch2_rd) |-> $past(sd_valid && sd_ready))
  else begin
    fail_count++;
    $error("ch2 strobe without an accepted save request");
  end

  // a failed load always holds the core
  fail_holds_core: assert property (@(posedge clk_ppu_21_47)
    loader_fail |-> core_reset)
  else begin
    fail_count++;
    $error("core_reset low while loader_fail is high");
  end

endmodule

bind nes_host_top nes_host_assert nes_host_assert_i (.*);

`default_nettype wire

// File: bench/nes_host_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "nes_host_defines.svh"

module nes_host_tb;

  import nes_host_pkg::*;

  logic clk_ppu_21_47;
  logic reset_nes, downloading, loader_busy, loader_done, loader_fail;
  mapper_flags_t loader_flags;
  mem_addr_t loader_addr;
  mem_data_t loader_wdata, ppu_wdata, sd_wdata;
  logic loader_write, ppu_read, ppu_write;
  ppu_addr_t ppu_addr;
  pad_buttons_t p1_pad, p2_pad, p3_pad, p4_pad;
  logic multitap_enabled, swap_controllers, joypad_strobe;
  logic [1:0] joypad_clock;
  logic sd_valid, sd_write, sd_read, ch2_busy;
  save_addr_t sd_addr;
  logic core_reset, loader_reset, has_save, joypad1_data, joypad2_data, sd_ready;
  mem_addr_t ch0_addr, ch2_addr;
  mem_data_t ch0_din, ch2_din;
  logic ch0_wr, ch0_rd, ch2_wr, ch2_rd;

  string lines[$];
  int total_cycles = 0;
  bit loaded = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cur_test = -1;
  int test_errors = 0;
  string bit_names[10] = '{"ch2_rd", "ch2_wr", "ch0_rd", "ch0_wr", "sd_ready",
                           "joypad2_data", "joypad1_data", "has_save", "loader_reset",
                           "core_reset"};

  nes_host_top nes_host_top_i (.*);

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #2 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  initial begin
    wait (loaded);
    #((total_cycles + `NES_RESET_COUNT + 100) * 4);
    $display("timeout: the vectors did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    // x in the golden file means don't care
    if (!$isunknown(exp)) begin
      checks++;
      if (got !== exp) begin
        errors++;
        test_errors++;
        $display("Error: %s got %0h expected %0h in test %0d", name, got, exp, cur_test);
      end
    end
  endtask

  task automatic finish_test();
    if (cur_test >= 0) begin
      tests_run++;
      if (test_errors != 0) begin
        tests_failed++;
      end
      $display("test %0d done, %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic start_test(int num);
    if (num != cur_test) begin
      finish_test();
      cur_test = num;
      test_errors = 0;
    end
  endtask

  task automatic run_cycle_line(string line);
    string op;
    int num, rep, n;
    logic [4:0] ctl;
    logic [6:0] bus;
    logic [31:0] flags;
    logic [24:0] a0, e_ch0a, e_ch2a;
    logic [21:0] a1;
    logic [7:0] d0, d1, e_ch0d, e_ch2d;
    logic [9:0] exp_bits, got_bits;
    n = $sscanf(line, "%s %d %d %b %b %h %h %h %h %h %b %h %h %h %h", op, num, rep, ctl,
                bus, flags, a0, d0, a1, d1, exp_bits, e_ch0a, e_ch0d, e_ch2a, e_ch2d);
    if (n != 15) begin
      errors++;
      $display("malformed vector line in the golden file: %s", line);
      return;
    end
    start_test(num);
    repeat (rep) begin
      @(negedge clk_ppu_21_47);
      {reset_nes, downloading, loader_busy, loader_done, loader_fail} = ctl;
      {loader_write, ppu_read, ppu_write, sd_valid, sd_write, sd_read, ch2_busy} = bus;
      loader_flags = {32'h0, flags};
      loader_addr = a0;
      loader_wdata = d0;
      ppu_addr = a1;
      ppu_wdata = d1;
      sd_addr = a1[17:0];
      sd_wdata = d1;
      @(posedge clk_ppu_21_47);
      #1;
      got_bits = {core_reset, loader_reset, has_save, joypad1_data, joypad2_data,
                  sd_ready, ch0_wr, ch0_rd, ch2_wr, ch2_rd};
      for (int i = 0; i < 10; i++) begin
        check_value(bit_names[i], got_bits[i], exp_bits[i]);
      end
      check_value("ch0_addr", ch0_addr, e_ch0a);
      check_value("ch0_din", ch0_din, e_ch0d);
      check_value("ch2_addr", ch2_addr, e_ch2a);
      check_value("ch2_din", ch2_din, e_ch2d);
    end
  endtask

  // strobe followed by 24 clock pulses on both ports
  task automatic run_serial_line(string line);
    string op;
    int num, n;
    logic mt, swap;
    logic [31:0] pads, s1, s2;
    n = $sscanf(line, "%s %d %b %b %h %h %h", op, num, mt, swap, pads, s1, s2);
    if (n != 7) begin
      errors++;
      $display("malformed serial line in the golden file: %s", line);
      return;
    end
    start_test(num);
    @(negedge clk_ppu_21_47);
    multitap_enabled = mt;
    swap_controllers = swap;
    {p4_pad, p3_pad, p2_pad, p1_pad} = pads;
    joypad_strobe = 1'b1;
    joypad_clock = 2'b00;
    @(posedge clk_ppu_21_47);
    #1;
    check_value("joypad1_data", joypad1_data, s1[0]);
    check_value("joypad2_data", joypad2_data, s2[0]);
    for (int k = 1; k <= 24; k++) begin
      @(negedge clk_ppu_21_47);
      joypad_strobe = 1'b0;
      joypad_clock = 2'b11;
      @(negedge clk_ppu_21_47);
      joypad_clock = 2'b00;
      @(posedge clk_ppu_21_47);
      #1;
      // bit 24 of the stream is the zero shifted in at the top
      check_value("joypad1_data", joypad1_data, s1[k]);
      check_value("joypad2_data", joypad2_data, s2[k]);
    end
  endtask

  initial begin
    int fd, rep, num;
    string line, op;
    {reset_nes, downloading, loader_busy, loader_done, loader_fail} = 5'b10000;
    loader_flags = '0;
    loader_addr = '0;
    loader_wdata = '0;
    loader_write = 1'b0;
    ppu_addr = '0;
    ppu_wdata = '0;
    ppu_read = 1'b0;
    ppu_write = 1'b0;
    {p1_pad, p2_pad, p3_pad, p4_pad} = '0;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    joypad_strobe = 1'b0;
    joypad_clock = 2'b00;
    {sd_valid, sd_write, sd_read, ch2_busy} = 4'b0000;
    sd_addr = '0;
    sd_wdata = '0;
    fd = $fopen("bench/nes_host_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 2 && line[0] != "#") begin
          lines.push_back(line);
          if (line[0] == "s") begin
            total_cycles += 49;
          end else if ($sscanf(line, "%s %d %d", op, num, rep) == 3) begin
            total_cycles += rep;
          end
        end
      end
      $fclose(fd);
      loaded = 1;
      if (lines.size() == 0) begin
        errors++;
        $display("the golden file holds no vectors");
      end
      foreach (lines[i]) begin
        if (lines[i][0] == "s") begin
          run_serial_line(lines[i]);
        end else begin
          run_cycle_line(lines[i]);
        end
      end
      finish_test();
      errors += nes_host_top_i.nes_host_assert_i.fail_count;
      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, checks, errors,
               nes_host_top_i.nes_host_assert_i.fail_count);
      if (errors == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: bench/nes_host_golden.txt
# c test rep ctl(rst dl busy done fail) bus(ldwr pprd ppwr sdv sdw sdr ch2busy) flags a0 d0 a1 d1
#   exp(core_rst ldr_rst has_save j1 j2 sd_ready ch0_wr ch0_rd ch2_wr ch2_rd) ch0a ch0d ch2a ch2d
# s test mt swap pads(p4 p3 p2 p1) port1 port2, streams lsb first, x is don't care
c 1 2 10000 0000000 00000000 0000000 00 000000 00 1000010000 0000000 00 xxxxxxx xx
c 1 5 00000 0000000 00000000 0000000 00 000000 00 1100010000 0000000 00 xxxxxxx xx
c 1 1 01000 0000000 00000000 0000000 00 000000 00 1100010000 0000000 00 xxxxxxx xx
c 1 3 01000 0000000 00000000 0000000 00 000000 00 1000010000 0000000 00 xxxxxxx xx
c 1 254 00000 0000000 00000000 0000000 00 000000 00 1000010000 0000000 00 xxxxxxx xx
c 1 1 00000 0000000 00000000 0000000 00 000000 00 0000010000 0000000 00 xxxxxxx xx
c 1 2 00000 0000000 00000000 0000000 00 000000 00 0100010000 0000000 00 xxxxxxx xx
c 1 1 00001 0000000 00000000 0000000 00 000000 00 1100010000 0000000 00 xxxxxxx xx
c 1 1 00000 0000000 00000000 0000000 00 000000 00 0100010000 0000000 00 xxxxxxx xx
s 2 0 0 4433c635 ffff35 ffffc6
c 4 1 00010 0000000 02000001 0000000 00 000000 00 0110010000 0000000 00 xxxxxxx xx
c 4 2 00000 0000000 00000000 0000000 00 000000 00 0110010000 0000000 00 xxxxxxx xx
c 4 1 01000 0000000 00000000 0000000 00 000000 00 1100010000 0000000 00 xxxxxxx xx
c 4 1 01000 0000000 00000000 0000000 00 000000 00 1000010000 0000000 00 xxxxxxx xx
c 4 254 00000 0000000 00000000 0000000 00 000000 00 1010010000 0000000 00 xxxxxxx xx
c 4 1 00000 0000000 00000000 0000000 00 000000 00 0010010000 0000000 00 xxxxxxx xx
c 4 1 00000 0000000 00000000 0000000 00 000000 00 0110010000 0000000 00 xxxxxxx xx
s 3 1 0 4433c635 083335 0444c6
s 3 1 1 4433c635 0833c6 044435
s 3 0 1 4433c635 ffffc6 ffff35
c 5 1 00100 1100000 00000000 1abcdef 5a 2a5a5a c3 0110011000 1abcdef 5a xxxxxxx xx
c 5 1 00000 0110000 00000000 1abcdef 5a 2a5a5a c3 0110011100 02a5a5a c3 xxxxxxx xx
c 5 1 00000 0000000 00000000 0000000 00 2a5a5a c3 0110010000 02a5a5a c3 xxxxxxx xx
c 6 3 00000 0001101 00000000 0000000 00 012345 77 0110000000 0012345 77 xxxxxxx xx
c 6 1 00000 0001100 00000000 0000000 00 012345 77 0110010010 0012345 77 03d2345 77
c 6 2 00000 0000000 00000000 0000000 00 012345 77 0110010000 0012345 77 03d2345 77
c 6 1 00000 0001010 00000000 0000000 00 000abc 00 0110010001 0000abc 00 03c0abc 00
c 6 1 00000 0000000 00000000 0000000 00 000abc 00 0110010000 0000abc 00 03c0abc 00

// File: build.f
+incdir+src
src/nes_host_pkg.sv
src/reset_sequencer.sv
src/cart_config_reg.sv
src/joypad_serializer.sv
src/mem_channel_mux.sv
src/nes_host_top.sv
bench/nes_host_assert.sv
bench/nes_host_tb.sv

// File: Bender.yml
package:
  name: nes_host

sources:
  - include_dirs:
      - src
    files:
      - src/nes_host_pkg.sv
      - src/reset_sequencer.sv
      - src/cart_config_reg.sv
      - src/joypad_serializer.sv
      - src/mem_channel_mux.sv
      - src/nes_host_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/nes_host_assert.sv
      - bench/nes_host_tb.sv
